//--- include/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// machine widths
`define RV_XLEN       32
`define RV_REG_COUNT  32
`define RV_REG_IDX_W  5

// first fetch address out of reset
`define RV_RESET_PC   32'h0000_0000

// major opcodes, instruction bits [6:0]
`define RV_OP_LUI     7'b0110111
`define RV_OP_AUIPC   7'b0010111
`define RV_OP_JAL     7'b1101111
`define RV_OP_JALR    7'b1100111
`define RV_OP_BRANCH  7'b1100011
`define RV_OP_LOAD    7'b0000011
`define RV_OP_STORE   7'b0100011
`define RV_OP_ALU_IMM 7'b0010011
`define RV_OP_ALU     7'b0110011
`define RV_OP_SYSTEM  7'b1110011

`endif

//--- design/rv_pkg.sv
`include "rv_params.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;

  typedef logic [`RV_REG_IDX_W-1:0] reg_idx_t;

  // instruction class, ecall and ebreak land in system
  typedef enum logic [3:0] {
    OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH,
    OP_LOAD, OP_STORE, OP_ALU, OP_SYSTEM, OP_ILLEGAL
  } op_class_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  // values follow funct3 of the branch encoding
  typedef enum logic [2:0] {
    BR_BEQ  = 3'b000,
    BR_BNE  = 3'b001,
    BR_BLT  = 3'b100,
    BR_BGE  = 3'b101,
    BR_BLTU = 3'b110,
    BR_BGEU = 3'b111
  } branch_op_e;

  // values follow funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } mem_size_e;

endpackage

//--- design/rv_decode.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_decode (
  input  logic               clk,
  input  logic               reset,
  input  logic               decode_en,
  input  rv_pkg::word_t      instr,
  output rv_pkg::op_class_e  op_class,
  output rv_pkg::alu_op_e    alu_op,
  output rv_pkg::branch_op_e branch_op,
  output rv_pkg::mem_size_e  mem_size,
  output logic               load_unsigned,
  output logic               use_imm,
  output rv_pkg::reg_idx_t   rd,
  output rv_pkg::reg_idx_t   rs1,
  output rv_pkg::reg_idx_t   rs2,
  output rv_pkg::word_t      imm
);
  import rv_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
  word_t      imm_d;
  op_class_e  class_d;
  alu_op_e    alu_d;
  logic       alt_ok;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  // funct7 may only be 0100000 on sub, sra and srai
  assign alt_ok = (opcode == `RV_OP_ALU) ?
      (funct7 == 7'b0 || (funct7 == 7'b0100000 && funct3 inside {3'b000, 3'b101})) :
      (funct3 == 3'b001) ? (funct7 == 7'b0) :
      (funct3 == 3'b101) ? (funct7 == 7'b0 || funct7 == 7'b0100000) : 1'b1;

  always_comb begin
    case (funct3)
      3'b000:  alu_d = (opcode == `RV_OP_ALU && funct7[5]) ? ALU_SUB : ALU_ADD;
      3'b001:  alu_d = ALU_SLL;
      3'b010:  alu_d = ALU_SLT;
      3'b011:  alu_d = ALU_SLTU;
      3'b100:  alu_d = ALU_XOR;
      3'b101:  alu_d = funct7[5] ? ALU_SRA : ALU_SRL;
      3'b110:  alu_d = ALU_OR;
      default: alu_d = ALU_AND;
    endcase
  end

  always_comb begin
    class_d = OP_ILLEGAL;
    imm_d   = imm_i;
    case (opcode)
      `RV_OP_LUI: begin
        class_d = OP_LUI;
        imm_d   = imm_u;
      end
      `RV_OP_AUIPC: begin
        class_d = OP_AUIPC;
        imm_d   = imm_u;
      end
      `RV_OP_JAL: begin
        class_d = OP_JAL;
        imm_d   = imm_j;
      end
      `RV_OP_JALR: begin
        if (funct3 == 3'b000) class_d = OP_JALR;
      end
      `RV_OP_BRANCH: begin
        if (funct3[2:1] != 2'b01) class_d = OP_BRANCH;
        imm_d = imm_b;
      end
      `RV_OP_LOAD: begin
        if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) class_d = OP_LOAD;
      end
      `RV_OP_STORE: begin
        if (funct3 inside {3'b000, 3'b001, 3'b010}) class_d = OP_STORE;
        imm_d = imm_s;
      end
      `RV_OP_ALU_IMM, `RV_OP_ALU: begin
        if (alt_ok) class_d = OP_ALU;
      end
      `RV_OP_SYSTEM: begin
        // only ecall and ebreak are known
        if (instr[31:21] == 11'b0 && instr[19:0] == 20'h00073) class_d = OP_SYSTEM;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      op_class <= OP_ILLEGAL;
      use_imm  <= 1'b0;
    end else if (decode_en) begin
      op_class <= class_d;
      use_imm  <= (opcode == `RV_OP_ALU_IMM);
    end
  end

  always_ff @(posedge clk) begin
    if (decode_en) begin
      alu_op        <= alu_d;
      branch_op     <= branch_op_e'(funct3);
      mem_size      <= mem_size_e'(funct3[1:0]);
      load_unsigned <= funct3[2];
      rd            <= instr[11:7];
      rs1           <= instr[19:15];
      rs2           <= instr[24:20];
      imm           <= imm_d;
    end
  end

endmodule

//--- design/rv_execute.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_execute (
  input  logic               clk,
  input  logic               reset,
  input  logic               exec_en,
  input  rv_pkg::op_class_e  op_class,
  input  rv_pkg::alu_op_e    alu_op,
  input  rv_pkg::branch_op_e branch_op,
  input  rv_pkg::mem_size_e  mem_size,
  input  logic               use_imm,
  input  rv_pkg::word_t      imm,
  input  rv_pkg::word_t      pc,
  input  rv_pkg::word_t      rs1_data,
  input  rv_pkg::word_t      rs2_data,
  output rv_pkg::word_t      result,
  output rv_pkg::word_t      next_pc,
  output rv_pkg::word_t      mem_addr_eff,
  output logic               fault
);
  import rv_pkg::*;

  word_t      op_b, alu_out, seq_pc, pc_imm, addr, result_d, next_d;
  logic [4:0] shamt;
  logic       taken, misaligned, is_mem, fault_d;

  assign op_b   = use_imm ? imm : rs2_data;
  // shift amount is the low five bits only
  assign shamt  = op_b[4:0];
  assign seq_pc = pc + 32'd4;
  assign pc_imm = pc + imm;
  assign addr   = rs1_data + imm;
  assign is_mem = op_class inside {OP_LOAD, OP_STORE};

  always_comb begin
    case (alu_op)
      ALU_SUB:  alu_out = rs1_data - op_b;
      ALU_SLL:  alu_out = rs1_data << shamt;
      ALU_SLT:  alu_out = word_t'($signed(rs1_data) < $signed(op_b));
      ALU_SLTU: alu_out = word_t'(rs1_data < op_b);
      ALU_XOR:  alu_out = rs1_data ^ op_b;
      ALU_SRL:  alu_out = rs1_data >> shamt;
      ALU_SRA:  alu_out = $signed(rs1_data) >>> shamt;
      ALU_OR:   alu_out = rs1_data | op_b;
      ALU_AND:  alu_out = rs1_data & op_b;
      default:  alu_out = rs1_data + op_b;
    endcase
  end

  always_comb begin
    case (branch_op)
      BR_BEQ:  taken = rs1_data == rs2_data;
      BR_BNE:  taken = rs1_data != rs2_data;
      BR_BLT:  taken = $signed(rs1_data) < $signed(rs2_data);
      BR_BGE:  taken = $signed(rs1_data) >= $signed(rs2_data);
      BR_BLTU: taken = rs1_data < rs2_data;
      BR_BGEU: taken = rs1_data >= rs2_data;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    result_d = alu_out;
    next_d   = seq_pc;
    case (op_class)
      OP_LUI:    result_d = imm;
      OP_AUIPC:  result_d = pc_imm;
      OP_JAL: begin
        result_d = seq_pc;
        next_d   = pc_imm;
      end
      OP_JALR: begin
        result_d = seq_pc;
        next_d   = {addr[`RV_XLEN-1:1], 1'b0};
      end
      OP_BRANCH: next_d = taken ? pc_imm : seq_pc;
      default: ;
    endcase
  end

  always_comb begin
    case (mem_size)
      SIZE_HALF: misaligned = addr[0];
      SIZE_WORD: misaligned = addr[1:0] != 2'b00;
      default:   misaligned = 1'b0;
    endcase
  end

  // no compressed support, so targets need both low bits clear
  assign fault_d = op_class inside {OP_ILLEGAL, OP_SYSTEM} || (is_mem && misaligned) ||
      next_d[1:0] != 2'b00;

  always_ff @(posedge clk) begin
    if (reset) begin
      fault <= 1'b0;
    end else if (exec_en) begin
      fault <= fault_d;
    end
  end

  always_ff @(posedge clk) begin
    if (exec_en) begin
      result       <= result_d;
      next_pc      <= next_d;
      mem_addr_eff <= addr;
    end
  end

  // decode hands over a known class
  assert property (@(posedge clk) disable iff (reset)
    exec_en |-> !$isunknown(op_class) && op_class inside {[OP_LUI:OP_ILLEGAL]});

endmodule

//--- design/rv_lsu.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_lsu (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  fetch_req,
  input  logic                  data_req,
  input  rv_pkg::word_t         fetch_addr,
  input  rv_pkg::word_t         data_addr,
  input  rv_pkg::word_t         store_data,
  input  logic                  is_store,
  input  rv_pkg::mem_size_e     mem_size,
  input  logic                  load_unsigned,
  output logic                  mem_valid,
  output logic                  mem_instr,
  output logic [`RV_XLEN-1:0]   mem_addr,
  output logic [`RV_XLEN-1:0]   mem_wdata,
  output logic [`RV_XLEN/8-1:0] mem_wstrb,
  input  logic                  mem_ready,
  input  logic [`RV_XLEN-1:0]   mem_rdata,
  output logic                  done,
  output rv_pkg::word_t         rdata
);
  import rv_pkg::*;

  logic [1:0]            lane, lane_q;
  mem_size_e             size_q;
  logic                  unsigned_q;
  word_t                 wdata_d, shifted, load_val;
  logic [`RV_XLEN/8-1:0] wstrb_d;

  assign lane = data_addr[1:0];

  // replicate the store value over the lanes, strobe picks the live one
  always_comb begin
    case (mem_size)
      SIZE_BYTE: begin
        wdata_d = {4{store_data[7:0]}};
        wstrb_d = 4'b0001 << lane;
      end
      SIZE_HALF: begin
        wdata_d = {2{store_data[15:0]}};
        wstrb_d = 4'b0011 << lane;
      end
      default: begin
        wdata_d = store_data;
        wstrb_d = 4'b1111;
      end
    endcase
  end

  assign shifted = mem_rdata >> {lane_q, 3'b000};

  always_comb begin
    case (size_q)
      SIZE_BYTE: load_val = {{24{~unsigned_q & shifted[7]}}, shifted[7:0]};
      SIZE_HALF: load_val = {{16{~unsigned_q & shifted[15]}}, shifted[15:0]};
      default:   load_val = mem_rdata;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_valid <= 1'b0;
      mem_instr <= 1'b0;
      mem_wstrb <= '0;
      done      <= 1'b0;
    end else begin
      done <= 1'b0;
      if (mem_valid) begin
        if (mem_ready) begin
          mem_valid <= 1'b0;
          done      <= 1'b1;
        end
      end else if (fetch_req) begin
        mem_valid <= 1'b1;
        mem_instr <= 1'b1;
        mem_wstrb <= '0;
      end else if (data_req) begin
        mem_valid <= 1'b1;
        mem_instr <= 1'b0;
        mem_wstrb <= is_store ? wstrb_d : '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!mem_valid && fetch_req) begin
      mem_addr <= fetch_addr;
    end else if (!mem_valid && data_req) begin
      mem_addr   <= {data_addr[`RV_XLEN-1:2], 2'b00};
      mem_wdata  <= wdata_d;
      lane_q     <= lane;
      size_q     <= mem_size;
      unsigned_q <= load_unsigned;
    end
    if (mem_valid && mem_ready) begin
      rdata <= mem_instr ? mem_rdata : load_val;
    end
  end

  // a pending request holds still until memory takes it
  assert property (@(posedge clk) disable iff (reset)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_wdata) &&
      $stable(mem_wstrb) && $stable(mem_instr));

  // fetch addresses rely on execute trapping bad targets
  assert property (@(posedge clk) disable iff (reset) mem_valid |-> mem_addr[1:0] == 2'b00);

  assert property (@(posedge clk) disable iff (reset) mem_valid && mem_instr |-> mem_wstrb == '0);

endmodule

//--- design/rv_core.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_core (
  input  logic                  clk,
  input  logic                  reset,
  output logic                  mem_valid,
  output logic                  mem_instr,
  output logic [`RV_XLEN-1:0]   mem_addr,
  output logic [`RV_XLEN-1:0]   mem_wdata,
  output logic [`RV_XLEN/8-1:0] mem_wstrb,
  input  logic                  mem_ready,
  input  logic [`RV_XLEN-1:0]   mem_rdata,
  output logic                  trap
);
  import rv_pkg::*;

  typedef enum logic [2:0] {
    ST_FETCH, ST_FETCH_WAIT, ST_DECODE, ST_EXEC, ST_MEM, ST_MEM_WAIT, ST_WB, ST_TRAP
  } state_e;

  state_e     state;
  word_t      pc;
  word_t      regs [`RV_REG_COUNT];
  op_class_e  d_class;
  alu_op_e    d_alu;
  branch_op_e d_branch;
  mem_size_e  d_size;
  logic       d_unsigned, d_use_imm;
  reg_idx_t   d_rd, d_rs1, d_rs2;
  word_t      d_imm, rs1_data, rs2_data;
  word_t      ex_result, ex_next_pc, ex_addr, lsu_rdata;
  logic       ex_fault, lsu_done, is_mem, writes_rd;
  logic       fetch_req, decode_en, exec_en, data_req;

  // x0 reads as zero whatever the array holds
  assign rs1_data = (d_rs1 == '0) ? '0 : regs[d_rs1];
  assign rs2_data = (d_rs2 == '0) ? '0 : regs[d_rs2];

  assign is_mem    = d_class inside {OP_LOAD, OP_STORE};
  assign writes_rd = !(d_class inside {OP_BRANCH, OP_STORE}) && d_rd != '0;

  assign fetch_req = state == ST_FETCH;
  assign decode_en = state == ST_DECODE;
  assign exec_en   = state == ST_EXEC;
  assign data_req  = state == ST_MEM && !ex_fault && is_mem;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_FETCH;
      pc    <= `RV_RESET_PC;
      trap  <= 1'b0;
    end else begin
      case (state)
        ST_FETCH:      state <= ST_FETCH_WAIT;
        ST_FETCH_WAIT: state <= lsu_done ? ST_DECODE : ST_FETCH_WAIT;
        ST_DECODE:     state <= ST_EXEC;
        ST_EXEC:       state <= ST_MEM;
        ST_MEM: begin
          if (ex_fault) begin
            trap  <= 1'b1;
            state <= ST_TRAP;
          end else begin
            state <= is_mem ? ST_MEM_WAIT : ST_WB;
          end
        end
        ST_MEM_WAIT:   state <= lsu_done ? ST_WB : ST_MEM_WAIT;
        ST_WB: begin
          pc    <= ex_next_pc;
          state <= ST_FETCH;
        end
        // trap parks here until reset
        default:       state <= ST_TRAP;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_WB && writes_rd) begin
      regs[d_rd] <= (d_class == OP_LOAD) ? lsu_rdata : ex_result;
    end
  end

  rv_decode u_decode (
    .clk(clk), .reset(reset), .decode_en(decode_en), .instr(lsu_rdata),
    .op_class(d_class), .alu_op(d_alu), .branch_op(d_branch), .mem_size(d_size),
    .load_unsigned(d_unsigned), .use_imm(d_use_imm),
    .rd(d_rd), .rs1(d_rs1), .rs2(d_rs2), .imm(d_imm)
  );

  rv_execute u_execute (
    .clk(clk), .reset(reset), .exec_en(exec_en),
    .op_class(d_class), .alu_op(d_alu), .branch_op(d_branch), .mem_size(d_size),
    .use_imm(d_use_imm), .imm(d_imm), .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .result(ex_result), .next_pc(ex_next_pc), .mem_addr_eff(ex_addr), .fault(ex_fault)
  );

  rv_lsu u_lsu (
    .clk(clk), .reset(reset), .fetch_req(fetch_req), .data_req(data_req),
    .fetch_addr(pc), .data_addr(ex_addr), .store_data(rs2_data),
    .is_store(d_class == OP_STORE), .mem_size(d_size), .load_unsigned(d_unsigned),
    .mem_valid(mem_valid), .mem_instr(mem_instr), .mem_addr(mem_addr),
    .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb), .mem_ready(mem_ready),
    .mem_rdata(mem_rdata), .done(lsu_done), .rdata(lsu_rdata)
  );

  // trap is sticky until reset
  assert property (@(posedge clk) disable iff (reset) trap |=> trap);

  // once trapped no new memory transfer starts
  assert property (@(posedge clk) disable iff (reset) trap |=> !$rose(mem_valid));

endmodule

//--- sim/core_checker.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module core_checker (
  input  logic        clk,
  input  logic        reset,
  input  logic        mem_valid,
  input  logic        mem_ready,
  input  logic        mem_instr,
  input  logic [31:0] mem_addr,
  input  logic [31:0] mem_wdata,
  input  logic [3:0]  mem_wstrb,
  input  logic        trap,
  input  int          test_idx,
  input  logic [31:0] exp_wdata,
  input  logic [3:0]  exp_wstrb,
  input  logic        exp_trap,
  input  logic        check_now,
  input  logic        report_now,
  output logic        seen,
  output int          pass_count,
  output int          fail_count
);

  logic        got_store = 1'b0;
  logic        late_req = 1'b0;
  logic [31:0] got_w = '0;
  logic [3:0]  got_s = '0;
  logic        fetch_seen = 1'b0;
  logic        fetch_instr = 1'b0;
  logic [31:0] fetch_addr = '0;
  int          fetch_cyc = 0;
  int          cyc = 0;
  int          n_pass = 0;
  int          n_fail = 0;

  assign seen       = got_store || trap;
  assign pass_count = n_pass;
  assign fail_count = n_fail;

  task automatic judge_test();
    logic ok;
    ok = 1'b1;
    // first request after reset is a fetch from the reset pc
    if (!fetch_seen || fetch_cyc > 2) begin
      $display("test %0d: no fetch request within 2 cycles of reset", test_idx);
      ok = 1'b0;
    end else begin
      if (fetch_instr != 1'b1) begin
        $display("[ERROR] test %0d mem_instr: got %h, expected %h", test_idx, fetch_instr, 1'b1);
        ok = 1'b0;
      end
      if (fetch_addr != `RV_RESET_PC) begin
        $display("[ERROR] test %0d mem_addr: got %h, expected %h", test_idx, fetch_addr,
                 `RV_RESET_PC);
        ok = 1'b0;
      end
    end
    if (exp_trap) begin
      if (!trap) begin
        $display("test %0d: trap did not rise", test_idx);
        ok = 1'b0;
      end else if (got_store) begin
        $display("test %0d: result store issued although the program trapped", test_idx);
        ok = 1'b0;
      end else if (late_req) begin
        $display("test %0d: memory request issued after trap", test_idx);
        ok = 1'b0;
      end
    end else if (trap) begin
      $display("test %0d: unexpected trap", test_idx);
      ok = 1'b0;
    end else if (!got_store) begin
      $display("test %0d: no store reached address 0x100", test_idx);
      ok = 1'b0;
    end else begin
      if (got_w != exp_wdata) begin
        $display("[ERROR] test %0d mem_wdata: got %h, expected %h", test_idx, got_w, exp_wdata);
        ok = 1'b0;
      end
      if (got_s != exp_wstrb) begin
        $display("[ERROR] test %0d mem_wstrb: got %h, expected %h", test_idx, got_s, exp_wstrb);
        ok = 1'b0;
      end
    end
    if (ok) begin
      $display("test %0d ok", test_idx);
      n_pass++;
    end else begin
      n_fail++;
    end
  endtask

  // sampled mid-cycle, away from the edges where inputs change
  always @(negedge clk) begin
    if (reset) begin
      got_store  <= 1'b0;
      late_req   <= 1'b0;
      fetch_seen <= 1'b0;
      cyc        <= 0;
    end else begin
      cyc <= cyc + 1;
      if (mem_valid && !fetch_seen) begin
        fetch_seen  <= 1'b1;
        fetch_instr <= mem_instr;
        fetch_addr  <= mem_addr;
        fetch_cyc   <= cyc;
      end
      if (mem_valid && mem_ready && mem_wstrb != 4'h0 && mem_addr == 32'h100 && !got_store) begin
        got_store <= 1'b1;
        got_w     <= mem_wdata;
        got_s     <= mem_wstrb;
      end
      if (trap && mem_valid) late_req <= 1'b1;
    end
    if (check_now) judge_test();
    if (report_now) begin
      $display("%0d tests, %0d passed, %0d failed", n_pass + n_fail, n_pass, n_fail);
    end
  end

endmodule

//--- sim/tb_core.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module tb_core;

  localparam int MAX_ROWS = 80;
  localparam int K_R = 0, K_I = 1, K_LUI = 2, K_AUIPC = 3, K_JAL = 4;
  localparam int K_JALR = 5, K_BR = 6, K_ST = 7, K_LD = 8, K_TRAP = 9;
  localparam logic [31:0] NOP = 32'h0000_0013;

  logic        clk = 1'b0;
  logic        reset = 1'b1;
  logic        mem_ready = 1'b0;
  logic [31:0] mem_rdata = '0;
  logic        mem_valid, mem_instr, trap, seen;
  logic [31:0] mem_addr, mem_wdata;
  logic [3:0]  mem_wstrb;

  integer      seed = 3;
  int          kind_t [MAX_ROWS];
  int          sub_t [MAX_ROWS];
  int          off_t [MAX_ROWS];
  logic [31:0] a_t [MAX_ROWS];
  logic [31:0] b_t [MAX_ROWS];
  logic [31:0] exp_w_t [MAX_ROWS];
  logic [3:0]  exp_s_t [MAX_ROWS];
  logic        trap_t [MAX_ROWS];
  logic        stall_t [MAX_ROWS];
  int          n_rows = 0;

  logic [31:0] mem [256];
  logic [31:0] prog [16];
  int          wait_cnt = 0;
  logic        stall_mode = 1'b0;
  int          cur = 0;
  logic [31:0] cur_w = '0;
  logic [3:0]  cur_s = '0;
  logic        cur_t = 1'b0;
  logic        check_now = 1'b0;
  logic        report_now = 1'b0;
  int          n_pass, n_fail;

  always #5 clk = ~clk;

  rv_core dut0 (
    .clk(clk), .reset(reset), .mem_valid(mem_valid), .mem_instr(mem_instr),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb),
    .mem_ready(mem_ready), .mem_rdata(mem_rdata), .trap(trap)
  );

  core_checker chk0 (
    .clk(clk), .reset(reset), .mem_valid(mem_valid), .mem_ready(mem_ready),
    .mem_instr(mem_instr),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb), .trap(trap),
    .test_idx(cur), .exp_wdata(cur_w), .exp_wstrb(cur_s), .exp_trap(cur_t),
    .check_now(check_now), .report_now(report_now), .seen(seen),
    .pass_count(n_pass), .fail_count(n_fail)
  );

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, `RV_OP_ALU};
  endfunction

  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], `RV_OP_STORE};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
  endfunction

  // upper part for lui so that the sign-extended addi lands on the value
  function automatic logic [19:0] hi20(logic [31:0] v);
    logic [31:0] t;
    t = v + 32'h800;
    return t[31:12];
  endfunction

  function automatic logic [31:0] alu_ref(logic [3:0] sel, logic [31:0] x, logic [31:0] y);
    case (sel[2:0])
      3'd0:    return sel[3] ? x - y : x + y;
      3'd1:    return x << y[4:0];
      3'd2:    return {31'b0, $signed(x) < $signed(y)};
      3'd3:    return {31'b0, x < y};
      3'd4:    return x ^ y;
      3'd5:    return sel[3] ? 32'($signed(x) >>> y[4:0]) : x >> y[4:0];
      3'd6:    return x | y;
      default: return x & y;
    endcase
  endfunction

  function automatic logic branch_taken(logic [2:0] f3, logic [31:0] x, logic [31:0] y);
    case (f3)
      3'd0:    return x == y;
      3'd1:    return x != y;
      3'd4:    return $signed(x) < $signed(y);
      3'd5:    return $signed(x) >= $signed(y);
      3'd6:    return x < y;
      default: return x >= y;
    endcase
  endfunction

  function automatic int next_delay();
    int d;
    d = $random(seed) % 3;
    if (d < 0) d = -d;
    return stall_mode ? 12 : d;
  endfunction

  // rnd bit 0 draws a, bit 1 draws b
  task automatic add_row(input int kind, input int sub, input int off, input logic [31:0] a,
                         input logic [31:0] b, input int rnd, input logic stall);
    logic [31:0] x, y, w, e;
    logic [3:0]  s;
    x = rnd[0] ? $random(seed) : a;
    y = rnd[1] ? $random(seed) : b;
    w = y >> (8 * off);
    e = '0;
    s = 4'hF;
    trap_t[n_rows] = 1'b0;
    case (kind)
      K_R:            e = alu_ref(4'(sub), x, y);
      K_I:            e = alu_ref(4'(sub), x, {{20{y[11]}}, y[11:0]});
      K_LUI:          e = {x[31:12], 12'h0};
      K_AUIPC:        e = 32'h10 + {x[31:12], 12'h0};
      K_JAL, K_JALR:  e = 32'd20;
      K_BR:           e = branch_taken(3'(sub), x, y) ? 32'd1 : 32'd2;
      K_ST: begin
        case (sub)
          0: begin
            e = {4{y[7:0]}};
            s = 4'b0001 << off;
          end
          1: begin
            e = {2{y[15:0]}};
            s = 4'b0011 << off;
          end
          default: e = y;
        endcase
      end
      K_LD: begin
        case (sub)
          0:       e = {{24{w[7]}}, w[7:0]};
          1:       e = {{16{w[15]}}, w[15:0]};
          4:       e = {24'h0, w[7:0]};
          5:       e = {16'h0, w[15:0]};
          default: e = y;
        endcase
      end
      default: trap_t[n_rows] = 1'b1;
    endcase
    kind_t[n_rows]  = kind;
    sub_t[n_rows]   = sub;
    off_t[n_rows]   = off;
    a_t[n_rows]     = x;
    b_t[n_rows]     = y;
    exp_w_t[n_rows] = e;
    exp_s_t[n_rows] = s;
    stall_t[n_rows] = stall;
    n_rows++;
  endtask

  task automatic build_table();
    int rsel [10] = '{0, 8, 1, 2, 3, 4, 5, 13, 6, 7};
    int bsel [6] = '{0, 1, 4, 5, 6, 7};
    foreach (rsel[i]) add_row(K_R, rsel[i], 0, 0, 0, 3, 1'b0);
    add_row(K_R, 2, 0, 32'hFFFF_FFFB, 32'd3, 0, 1'b0);
    // only the low five bits of rs2 shift
    add_row(K_R, 1, 0, 32'd1, 32'h0000_0FE4, 0, 1'b0);
    add_row(K_I, 0, 0, 0, 32'h801, 1, 1'b0);
    add_row(K_I, 2, 0, 32'hFFFF_FFF0, 32'hFFF, 0, 1'b0);
    add_row(K_I, 3, 0, 32'd5, 32'hFFF, 0, 1'b0);
    add_row(K_I, 4, 0, 0, 32'h555, 1, 1'b0);
    add_row(K_I, 6, 0, 0, 32'h0F0, 1, 1'b0);
    add_row(K_I, 7, 0, 0, 32'h7FF, 1, 1'b0);
    add_row(K_I, 1, 0, 0, 32'h01F, 1, 1'b0);
    add_row(K_I, 5, 0, 0, 32'h01F, 1, 1'b0);
    add_row(K_I, 13, 0, 32'h8000_00F0, 32'h408, 0, 1'b0);
    add_row(K_LUI, 0, 0, 32'hABCD_E123, 0, 0, 1'b0);
    add_row(K_AUIPC, 0, 0, 32'h0000_1000, 0, 0, 1'b0);
    add_row(K_JAL, 0, 0, 0, 0, 0, 1'b0);
    add_row(K_JALR, 0, 0, 0, 0, 0, 1'b0);
    foreach (bsel[i]) begin
      add_row(K_BR, bsel[i], 0, 32'd5, 32'd5, 0, 1'b0);
      add_row(K_BR, bsel[i], 0, 32'hFFFF_FFFF, 32'd1, 0, 1'b0);
      add_row(K_BR, bsel[i], 0, 32'd1, 32'hFFFF_FFFF, 0, 1'b0);
    end
    for (int k = 0; k < 4; k++) add_row(K_ST, 0, k, 0, 32'h1234_56A7, 0, 1'b0);
    for (int k = 0; k < 4; k += 2) add_row(K_ST, 1, k, 0, 32'h1234_C6A7, 0, 1'b0);
    add_row(K_ST, 2, 0, 0, 32'hDEAD_BEEF, 0, 1'b0);
    for (int k = 0; k < 4; k++) begin
      add_row(K_LD, 0, k, 0, 32'h8765_F172, 0, 1'b0);
      add_row(K_LD, 4, k, 0, 32'h8765_F172, 0, 1'b0);
    end
    for (int k = 0; k < 4; k += 2) begin
      add_row(K_LD, 1, k, 0, 32'h8765_7172, 0, 1'b0);
      add_row(K_LD, 5, k, 0, 32'h8765_7172, 0, 1'b0);
    end
    add_row(K_LD, 2, 0, 0, 32'h8765_F172, 0, 1'b0);
    for (int t = 0; t < 5; t++) add_row(K_TRAP, t, 0, 0, 32'h55, 0, 1'b0);
    // long ready stalls on a register op and on a store/load pair
    add_row(K_R, 0, 0, 0, 0, 3, 1'b1);
    add_row(K_LD, 1, 2, 0, 32'hF00D_8001, 0, 1'b1);
  endtask

  // x1 = a, x2 = b, test code at 0x10, result store at 0x1c, self loop at 0x20
  task automatic load_program(input int i);
    logic [31:0] a, b;
    logic [2:0]  f3;
    logic [11:0] k;
    a  = a_t[i];
    b  = b_t[i];
    f3 = 3'(sub_t[i]);
    k  = 12'(off_t[i]);
    foreach (prog[j]) prog[j] = NOP;
    prog[0] = {hi20(a), 5'd1, `RV_OP_LUI};
    prog[1] = enc_i(a[11:0], 5'd1, 3'd0, 5'd1, `RV_OP_ALU_IMM);
    prog[2] = {hi20(b), 5'd2, `RV_OP_LUI};
    prog[3] = enc_i(b[11:0], 5'd2, 3'd0, 5'd2, `RV_OP_ALU_IMM);
    prog[7] = enc_s(12'h100, 5'd3, 5'd0, 3'd2);
    prog[8] = enc_j(21'd0, 5'd0);
    case (kind_t[i])
      K_R:     prog[4] = enc_r(sub_t[i] > 7 ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'd3);
      K_I:     prog[4] = enc_i(b[11:0], 5'd1, f3, 5'd3, `RV_OP_ALU_IMM);
      K_LUI:   prog[4] = {a[31:12], 5'd3, `RV_OP_LUI};
      K_AUIPC: prog[4] = {a[31:12], 5'd3, `RV_OP_AUIPC};
      K_JAL: begin
        prog[4] = enc_j(21'd8, 5'd3);
        // overwrites the link unless the jump skips it
        prog[5] = enc_i(12'd2, 5'd0, 3'd0, 5'd3, `RV_OP_ALU_IMM);
      end
      // target 25 has bit 0 cleared to 24
      K_JALR: begin
        prog[4] = enc_i(12'd25, 5'd0, 3'd0, 5'd3, `RV_OP_JALR);
        prog[5] = enc_i(12'd2, 5'd0, 3'd0, 5'd3, `RV_OP_ALU_IMM);
      end
      K_BR: begin
        prog[4] = enc_i(12'd1, 5'd0, 3'd0, 5'd3, `RV_OP_ALU_IMM);
        prog[5] = enc_b(13'd8, 5'd2, 5'd1, f3);
        prog[6] = enc_i(12'd2, 5'd0, 3'd0, 5'd3, `RV_OP_ALU_IMM);
      end
      K_ST: begin
        prog[4] = enc_s(12'h100 + k, 5'd2, 5'd0, f3);
        prog[7] = NOP;
      end
      K_LD: begin
        prog[4] = enc_s(12'h200, 5'd2, 5'd0, 3'd2);
        prog[5] = enc_i(12'h200 + k, 5'd0, f3, 5'd3, `RV_OP_LOAD);
      end
      default: begin
        case (sub_t[i])
          0:       prog[4] = 32'h0000_0000;
          1:       prog[4] = 32'h0000_0073;
          2:       prog[4] = enc_i(12'h101, 5'd0, 3'd2, 5'd3, `RV_OP_LOAD);
          3:       prog[4] = enc_s(12'h103, 5'd2, 5'd0, 3'd1);
          default: prog[4] = enc_j(21'd6, 5'd3);
        endcase
      end
    endcase
  endtask

  // word memory, ready after a random wait, program copied in during reset
  always begin
    @(posedge clk);
    #1;
    if (reset) begin
      for (int w = 0; w < 256; w++) mem[w] = (w < 16) ? prog[w] : (32'hDEAD_0000 | 32'(w));
      mem_ready = 1'b0;
      wait_cnt  = next_delay();
    end else if (mem_ready) begin
      mem_ready = 1'b0;
    end else if (mem_valid) begin
      if (wait_cnt > 0) begin
        wait_cnt--;
      end else begin
        mem_rdata = mem[mem_addr[9:2]];
        for (int j = 0; j < 4; j++) begin
          if (mem_wstrb[j]) mem[mem_addr[9:2]][8*j +: 8] = mem_wdata[8*j +: 8];
        end
        mem_ready = 1'b1;
        wait_cnt  = next_delay();
      end
    end
  end

  initial begin
    #1;
    repeat (n_rows * 300) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", n_rows * 300);
    $display("Checks failed");
    $finish;
  end

  initial begin
    foreach (prog[j]) prog[j] = NOP;
    build_table();
    for (int i = 0; i < n_rows; i++) begin
      load_program(i);
      @(posedge clk);
      #1;
      reset      = 1'b1;
      stall_mode = stall_t[i];
      cur        = i;
      cur_w      = exp_w_t[i];
      cur_s      = exp_s_t[i];
      cur_t      = trap_t[i];
      repeat (3) @(posedge clk);
      #1;
      reset = 1'b0;
      while (!seen) @(posedge clk);
      // quiet window to catch requests after a trap
      repeat (20) @(posedge clk);
      #1;
      check_now = 1'b1;
      @(posedge clk);
      #1;
      check_now = 1'b0;
    end
    report_now = 1'b1;
    @(posedge clk);
    #1;
    report_now = 1'b0;
    if (n_fail == 0 && n_pass == n_rows) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+include
design/rv_pkg.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_lsu.sv
design/rv_core.sv
sim/core_checker.sv
sim/tb_core.sv

//--- run.sh
#!/usr/bin/env bash
# builds the core testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f project.f --top-module tb_core -o tb_core_sim \
  > build.log 2>&1 && ./obj_dir/tb_core_sim > sim.log 2>&1 || { echo "build or run error"; cat build.log; }

[ -f sim.log ] && cat sim.log
grep -qx "All checks passed" sim.log && { echo "PASS"; exit 0; } || { echo "FAIL"; exit 1; }
